// File: Makefile
VERILATOR ?= verilator
TOP       := tb_fp_div
FILELIST  := tb.f
FLAGS     := --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf $(OBJ_DIR)

// File: logic/fp_classify.sv
// Operand classification
// Splits both operands, decodes zero, infinity and NaN, and forms the
// result sign, raw biased exponent and the two significands
module fp_classify (
    input  fp_div_pkg::fp_t       op_a,
    input  fp_div_pkg::fp_t       op_b,
    output fp_div_pkg::fp_class_t cls,
    output logic                  sign,
    output fp_div_pkg::exp_ext_t  raw_exp,
    output fp_div_pkg::sig_t      sig_a,
    output fp_div_pkg::sig_t      sig_b
);
    import fp_div_pkg::*;

    logic  sign_a, sign_b;
    exp_t  exp_a, exp_b;
    mant_t mant_a, mant_b;
    logic  zero_a, zero_b;
    logic  inf_a, inf_b;
    logic  nan_a, nan_b;

    assign {sign_a, exp_a, mant_a} = op_a;
    assign {sign_b, exp_b, mant_b} = op_b;

    // Subnormals fall in with zero
    assign zero_a = (exp_a == '0);
    assign zero_b = (exp_b == '0);

    assign inf_a = (&exp_a) && (mant_a == '0);
    assign inf_b = (&exp_b) && (mant_b == '0);
    assign nan_a = (&exp_a) && (mant_a != '0);
    assign nan_b = (&exp_b) && (mant_b != '0);

    always_comb begin
        if (nan_a || nan_b || (zero_a && zero_b) || (inf_a && inf_b)) begin
            cls = CLS_NAN;
        end else if (inf_a || zero_b) begin
            cls = CLS_INF;
        end else if (zero_a || inf_b) begin
            cls = CLS_ZERO;
        end else begin
            cls = CLS_NORMAL;
        end
    end

    assign sign = sign_a ^ sign_b;

    // Spare top bit keeps the borrow of a small quotient
    assign raw_exp = {1'b0, exp_a} - {1'b0, exp_b} + exp_ext_t'(EXP_BIAS);

    // Hidden bit is always one here since the divider only sees normal pairs
    assign sig_a = {1'b1, mant_a};
    assign sig_b = {1'b1, mant_b};

endmodule

// File: logic/fp_div_ctrl.sv
// Divide unit control
// Runs both stream handshakes, holds the operands and the result,
// and launches the mantissa divider for ordinary operands
module fp_div_ctrl (
    input  logic                 CLK,
    input  logic                 nRST,
    input  fp_div_pkg::div_req_t req,
    output logic                 ready_in,
    output fp_div_pkg::div_rsp_t rsp,
    input  logic                 ready_out,
    output fp_div_pkg::fp_t      op_a,
    output fp_div_pkg::fp_t      op_b,
    input  fp_div_pkg::fp_class_t cls,
    output logic                 start,
    input  logic                 done,
    input  fp_div_pkg::fp_t      packed_result
);
    import fp_div_pkg::*;

    ctrl_state_t state;
    logic        launch;
    logic        bypass;
    logic        out_valid;
    fp_t         out_result;
    logic        accept;
    logic        load_result;

    assign accept = req.valid && ready_in;

    // Class is known the cycle after capture; only ordinary pairs use the divider
    assign start = launch && (cls == CLS_NORMAL);

    // Special results wait one cycle on the registered bypass flag
    assign load_result = bypass || done;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= S_IDLE;
            ready_in  <= 1'b0;
            out_valid <= 1'b0;
            launch    <= 1'b0;
            bypass    <= 1'b0;
        end else begin
            launch <= 1'b0;
            bypass <= launch && (cls != CLS_NORMAL);
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        ready_in <= 1'b0;
                        launch   <= 1'b1;
                        state    <= S_DIVIDE;
                    end else begin
                        ready_in <= 1'b1;
                    end
                end
                S_DIVIDE: begin
                    if (load_result) begin
                        out_valid <= 1'b1;
                        state     <= S_HOLD;
                    end
                end
                S_HOLD: begin
                    // Result stays put until the consumer takes it
                    if (ready_out) begin
                        out_valid <= 1'b0;
                        ready_in  <= 1'b1;
                        state     <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            op_a <= req.operand_a;
            op_b <= req.operand_b;
        end
        if (load_result) begin
            out_result <= packed_result;
        end
    end

    assign rsp = '{valid: out_valid, result: out_result};

endmodule

// File: logic/fp_div_pkg.sv
// Half-precision divide unit shared definitions
// Format constants, width types, class and state enums, stream structs
package fp_div_pkg;

    localparam int EXP_WIDTH  = 5;
    localparam int MANT_WIDTH = 10;
    localparam int FP_WIDTH   = 1 + EXP_WIDTH + MANT_WIDTH;
    localparam int EXP_BIAS   = 15;

    // Largest biased exponent of a finite number
    localparam int EXP_MAX    = (1 << EXP_WIDTH) - 2;

    // Significand and quotient widths derived from the mantissa
    localparam int SIG_WIDTH  = MANT_WIDTH + 1;
    localparam int QUOT_WIDTH = MANT_WIDTH + 3;
    localparam int ITER_WIDTH = $clog2(QUOT_WIDTH);

    typedef logic [FP_WIDTH-1:0]   fp_t;
    typedef logic [EXP_WIDTH-1:0]  exp_t;
    typedef logic [EXP_WIDTH:0]    exp_ext_t;
    typedef logic [MANT_WIDTH-1:0] mant_t;
    typedef logic [SIG_WIDTH-1:0]  sig_t;
    typedef logic [QUOT_WIDTH-1:0] quot_t;

    // Result class picked from the operand pair
    typedef enum logic [1:0] {
        CLS_NORMAL,
        CLS_ZERO,
        CLS_INF,
        CLS_NAN
    } fp_class_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_DIVIDE,
        S_HOLD
    } ctrl_state_t;

    typedef struct packed {
        logic valid;
        fp_t  operand_a;
        fp_t  operand_b;
    } div_req_t;

    typedef struct packed {
        logic valid;
        fp_t  result;
    } div_rsp_t;

endpackage

// File: logic/fp_div_unit.sv
// Half-precision divide unit for one vector lane
// Streams in and out with one operation in flight at a time
module fp_div_unit (
    input  logic                 CLK,
    input  logic                 nRST,
    input  fp_div_pkg::div_req_t req,
    output logic                 ready_in,
    output fp_div_pkg::div_rsp_t rsp,
    input  logic                 ready_out
);
    import fp_div_pkg::*;

    fp_t       op_a, op_b;
    fp_class_t cls;
    logic      sign;
    exp_ext_t  raw_exp;
    sig_t      sig_a, sig_b;
    logic      start;
    logic      done;
    quot_t     quotient;
    fp_t       packed_result;

    fp_div_ctrl u_ctrl (
        .CLK           (CLK),
        .nRST          (nRST),
        .req           (req),
        .ready_in      (ready_in),
        .rsp           (rsp),
        .ready_out     (ready_out),
        .op_a          (op_a),
        .op_b          (op_b),
        .cls           (cls),
        .start         (start),
        .done          (done),
        .packed_result (packed_result)
    );

    fp_classify u_classify (
        .op_a    (op_a),
        .op_b    (op_b),
        .cls     (cls),
        .sign    (sign),
        .raw_exp (raw_exp),
        .sig_a   (sig_a),
        .sig_b   (sig_b)
    );

    mant_divider u_divider (
        .CLK      (CLK),
        .nRST     (nRST),
        .start    (start),
        .sig_a    (sig_a),
        .sig_b    (sig_b),
        .quotient (quotient),
        .done     (done)
    );

    fp_normalize u_normalize (
        .cls           (cls),
        .sign          (sign),
        .raw_exp       (raw_exp),
        .quotient      (quotient),
        .packed_result (packed_result)
    );

endmodule

// File: logic/fp_normalize.sv
// Quotient normalisation and result packing
// Aligns and rounds the quotient, catches exponent overflow and underflow,
// and picks the final word from the operand class
module fp_normalize (
    input  fp_div_pkg::fp_class_t cls,
    input  logic                  sign,
    input  fp_div_pkg::exp_ext_t  raw_exp,
    input  fp_div_pkg::quot_t     quotient,
    output fp_div_pkg::fp_t       packed_result
);
    import fp_div_pkg::*;

    mant_t             frac;
    logic              rnd;
    logic [MANT_WIDTH:0] frac_sum;
    exp_ext_t          exp_n;
    exp_ext_t          exp_r;
    logic              borrow;
    logic              ovf;
    logic              udf;
    fp_t               nan_word;
    fp_t               inf_word;
    fp_t               zero_word;

    always_comb begin
        if (quotient[QUOT_WIDTH-1]) begin
            frac  = quotient[QUOT_WIDTH-2 -: MANT_WIDTH];
            rnd   = quotient[QUOT_WIDTH-MANT_WIDTH-2];
            exp_n = raw_exp;
        end else begin
            frac  = quotient[QUOT_WIDTH-3 -: MANT_WIDTH];
            rnd   = quotient[QUOT_WIDTH-MANT_WIDTH-3];
            exp_n = raw_exp - 1'b1;
        end
    end

    // A carry out of the half-up rounded fraction bumps the exponent
    assign frac_sum = {1'b0, frac} + {{MANT_WIDTH{1'b0}}, rnd};
    assign exp_r    = exp_n + {{EXP_WIDTH{1'b0}}, frac_sum[MANT_WIDTH]};

    // Exponents span -15 to 45, so a leading 11 can only be a borrow
    assign borrow = &exp_r[EXP_WIDTH -: 2];
    assign ovf    = !borrow && (exp_r > exp_ext_t'(EXP_MAX));
    assign udf    = borrow || (exp_r == '0);

    assign nan_word  = {sign, {EXP_WIDTH{1'b1}}, 1'b1, {(MANT_WIDTH-1){1'b0}}};
    assign inf_word  = {sign, {EXP_WIDTH{1'b1}}, {MANT_WIDTH{1'b0}}};
    assign zero_word = {sign, {(EXP_WIDTH+MANT_WIDTH){1'b0}}};

    always_comb begin
        case (cls)
            CLS_NAN:  packed_result = nan_word;
            CLS_INF:  packed_result = inf_word;
            CLS_ZERO: packed_result = zero_word;
            default: begin
                if (ovf) begin
                    packed_result = inf_word;
                end else if (udf) begin
                    packed_result = zero_word;
                end else begin
                    packed_result = {sign, exp_r[EXP_WIDTH-1:0], frac_sum[MANT_WIDTH-1:0]};
                end
            end
        endcase
    end

endmodule

// File: logic/mant_divider.sv
// Iterative non-restoring significand divider
// Produces one quotient bit per cycle, the first in the start cycle,
// and holds the quotient after done until the next start
module mant_divider (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                start,
    input  fp_div_pkg::sig_t    sig_a,
    input  fp_div_pkg::sig_t    sig_b,
    output fp_div_pkg::quot_t   quotient,
    output logic                done
);
    import fp_div_pkg::*;

    logic                  busy;
    logic [ITER_WIDTH-1:0] count;
    logic [QUOT_WIDTH-1:0] rem;
    logic [QUOT_WIDTH-1:0] rem_next;
    logic [QUOT_WIDTH-1:0] rem_shift;
    logic [QUOT_WIDTH-1:0] divisor;
    logic [QUOT_WIDTH-1:0] dividend_ext;
    logic [QUOT_WIDTH-1:0] divisor_ext;

    assign dividend_ext = {{(QUOT_WIDTH-SIG_WIDTH){1'b0}}, sig_a};
    assign divisor_ext  = {{(QUOT_WIDTH-SIG_WIDTH){1'b0}}, sig_b};
    assign rem_shift    = {rem[QUOT_WIDTH-2:0], 1'b0};

    // Remainder stays within +/- divisor, so two spare bits cover 2r
    always_comb begin
        if (start) begin
            rem_next = dividend_ext - divisor_ext;
        end else if (rem[QUOT_WIDTH-1]) begin
            rem_next = rem_shift + divisor;
        end else begin
            rem_next = rem_shift - divisor;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy  <= 1'b0;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                count <= ITER_WIDTH'(QUOT_WIDTH - 1);
            end else if (busy) begin
                count <= count - 1'b1;
                if (count == ITER_WIDTH'(1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (start) begin
            divisor <= divisor_ext;
        end
        if (start || busy) begin
            rem      <= rem_next;
            // Non-negative remainder means a one in this position
            quotient <= {quotient[QUOT_WIDTH-2:0], ~rem_next[QUOT_WIDTH-1]};
        end
    end

endmodule

// File: sim/fp_div_assert.sv
// Handshake and reset checks for the divide unit
// Bound into the top level of the DUT
module fp_div_assert (
    input logic                 CLK,
    input logic                 nRST,
    input fp_div_pkg::div_rsp_t rsp,
    input logic                 ready_in,
    input logic                 ready_out
);
    int error_count = 0;

    // Both stream outputs stay low while reset is held
    reset_low: assert property (@(posedge CLK) !nRST |=> !rsp.valid && !ready_in)
        else begin
            $error("rsp.valid or ready_in high during reset");
            error_count++;
        end

    // A stalled result keeps its value
    hold_stable: assert property (@(posedge CLK) disable iff (!nRST)
        rsp.valid && !ready_out |=> rsp.valid && $stable(rsp.result))
        else begin
            $error("rsp.result changed or dropped while stalled");
            error_count++;
        end

    one_side: assert property (@(posedge CLK) disable iff (!nRST)
        !(ready_in && rsp.valid))
        else begin
            $error("ready_in and rsp.valid high together");
            error_count++;
        end

endmodule

bind fp_div_unit fp_div_assert u_assert (
    .CLK       (CLK),
    .nRST      (nRST),
    .rsp       (rsp),
    .ready_in  (ready_in),
    .ready_out (ready_out)
);

// File: sim/fp_div_golden.hex
// operand_a operand_b expected_result group_tag
// tag 1 normal, 2 special operands, 3 range limits, 4 mixed under back-pressure
4600 4000 4200 01
3c00 4200 3555 01
4900 4200 42ab 01
4500 4700 39b7 01
c880 4100 c333 01
4200 3d00 40cd 01
3c00 4700 3092 01
7e00 3c00 7e00 02
bc00 7c01 fe00 02
0000 8000 fe00 02
7c00 7c00 7e00 02
c000 0000 fc00 02
0000 c200 8000 02
4500 fc00 8000 02
0001 3c00 0000 02
3c00 83ff fc00 02
7400 3800 7800 03
7800 3800 7c00 03
fbff 0400 fc00 03
0400 c000 8000 03
0400 7800 0000 03
0400 3e00 0000 03
c700 4500 bd9a 04
7c00 3c00 7c00 04
3c00 3c66 3b46 04
8000 fc00 0000 04
4700 4700 3c00 04
0200 0010 7e00 04

// File: sim/tb_fp_div.sv
// Testbench for the half-precision divide unit
// Plays golden vectors through the input stream with random gaps and
// random output stalls, and checks every result in order of issue
module tb_fp_div;
    import fp_div_pkg::*;

    localparam int MAX_VEC        = 64;
    localparam int WORDS          = 4;
    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 8;
    localparam int CYCLES_PER_VEC = 20;
    localparam int MARGIN_CYCLES  = 200;

    logic     CLK;
    logic     nRST;
    div_req_t req;
    logic     ready_in;
    div_rsp_t rsp;
    logic     ready_out;

    // Four words per vector hold operand_a, operand_b, expected result and group tag
    logic [15:0] golden [0:MAX_VEC*WORDS-1];
    int          num_vec;
    int          next_vec;
    int          gap;
    logic        drop_valid;
    int          exp_q[$];
    int          pass_count;
    int          fail_count;
    logic [31:0] rng;

    fp_div_unit uut (
        .CLK       (CLK),
        .nRST      (nRST),
        .req       (req),
        .ready_in  (ready_in),
        .rsp       (rsp),
        .ready_out (ready_out)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic string group_name(input logic [15:0] tag);
        case (tag)
            16'd1:   return "normal";
            16'd2:   return "special";
            16'd3:   return "range";
            16'd4:   return "mixed";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_result(input int idx, input fp_t actual);
        fp_t   expected;
        string name;
        expected = golden[idx*WORDS+2];
        name     = $sformatf("%s_%0d", group_name(golden[idx*WORDS+3]), idx);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            fail_count++;
        end else begin
            $display("PASS %s: %h / %h = %h", name, golden[idx*WORDS],
                     golden[idx*WORDS+1], actual);
            pass_count++;
        end
    endtask

    // Outputs seen on a falling edge hold until the next rising edge
    task automatic drive_cycle();
        int idx;
        if (ready_in && exp_q.size() > 0) begin
            $display("ready_in is high while an operation is still pending");
            fail_count++;
        end
        if (rsp.valid && exp_q.size() == 0) begin
            $display("rsp.valid is high with no operation pending");
            fail_count++;
        end

        // Output side stalls at random about one cycle in four
        rng = xorshift32(rng);
        ready_out = (rng[1:0] != 2'b00);
        if (rsp.valid && ready_out && exp_q.size() > 0) begin
            idx = exp_q.pop_front();
            check_result(idx, rsp.result);
        end

        // Input side
        if (drop_valid) begin
            req.valid  = 1'b0;
            drop_valid = 1'b0;
        end
        if (!req.valid && next_vec < num_vec) begin
            if (gap > 0) begin
                if (ready_in) begin
                    gap--;
                end
            end else begin
                req.valid     = 1'b1;
                req.operand_a = golden[next_vec*WORDS];
                req.operand_b = golden[next_vec*WORDS+1];
            end
        end
        if (req.valid && ready_in) begin
            // Taken on the coming rising edge
            exp_q.push_back(next_vec);
            next_vec++;
            drop_valid = 1'b1;
            rng = xorshift32(rng);
            gap = int'(rng[4:3]);
        end
    endtask

    initial begin
        int i;
        int waited;
        nRST       = 1'b0;
        req        = '0;
        ready_out  = 1'b0;
        rng        = 32'd22203;
        gap        = 0;
        next_vec   = 0;
        drop_valid = 1'b0;
        pass_count = 0;
        fail_count = 0;
        num_vec    = 0;

        // Zero tags mark the end of the vector list
        for (i = 0; i < MAX_VEC*WORDS; i++) begin
            golden[i] = '0;
        end
        $readmemh("sim/fp_div_golden.hex", golden);
        while (num_vec < MAX_VEC && golden[num_vec*WORDS+3] != 16'd0) begin
            num_vec++;
        end
        if (num_vec == 0) begin
            $display("no vectors could be read from the golden file");
            fail_count++;
        end

        // Reset test
        repeat (RESET_CYCLES) begin
            @(negedge CLK);
            if (rsp.valid || ready_in) begin
                $display("rsp.valid or ready_in is high while reset is held");
                fail_count++;
            end
        end
        nRST = 1'b1;
        waited = 0;
        while (!ready_in && waited < 4) begin
            @(negedge CLK);
            waited++;
        end
        if (ready_in && !rsp.valid) begin
            $display("PASS reset: ready_in high after %0d cycles", waited);
            pass_count++;
        end else begin
            $display("reset: ready_in did not rise or rsp.valid is high after reset");
            fail_count++;
        end

        while (next_vec < num_vec || exp_q.size() > 0) begin
            @(negedge CLK);
            drive_cycle();
        end

        repeat (2) @(negedge CLK);
        if (rsp.valid) begin
            $display("an extra result appeared after the last vector");
            fail_count++;
        end

        fail_count = fail_count + uut.u_assert.error_count;
        $display("%0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog sized from the number of vectors read
    initial begin
        wait (num_vec > 0);
        #((num_vec * CYCLES_PER_VEC + MARGIN_CYCLES) * CLK_PERIOD);
        $display("watchdog: the run did not finish in time, %0d results outstanding",
                 exp_q.size() + num_vec - next_vec);
        $display("tests failed");
        $finish;
    end

endmodule

// File: tb.f
logic/fp_div_pkg.sv
logic/fp_div_ctrl.sv
logic/fp_classify.sv
logic/mant_divider.sv
logic/fp_normalize.sv
logic/fp_div_unit.sv
sim/fp_div_assert.sv
sim/tb_fp_div.sv
